// File: logic/lce_msg_pkg.sv
/* Coherence message definitions for one LCE. Data beats are 64 bits wide.
   Message type codes are only meaningful together with their channel. */
`default_nettype none

package lce_msg_pkg;

  typedef logic [31:0] paddr_t;
  typedef logic [1:0]  lce_id_t;
  typedef logic [2:0]  way_t;

  // Log2 of the message size in bytes, 0 to 6 covers 1 to 64 bytes.
  typedef logic [2:0]  msg_size_t;

  localparam int fill_width = 64;
  typedef logic [fill_width-1:0] fill_data_t;

  // Log2 of the bytes in one fill beat.
  localparam msg_size_t fill_size_lg = 3'd3;

  typedef logic [2:0] msg_type_t;

  // Request channel.
  localparam msg_type_t req_rd_miss = 3'd0;
  localparam msg_type_t req_wr_miss = 3'd1;
  localparam msg_type_t req_uc_rd   = 3'd2;
  localparam msg_type_t req_uc_wr   = 3'd3;

  // Command channel.
  localparam msg_type_t cmd_inv       = 3'd0;
  localparam msg_type_t cmd_set_state = 3'd1;
  localparam msg_type_t cmd_data      = 3'd2;
  localparam msg_type_t cmd_uc_data   = 3'd3;
  localparam msg_type_t cmd_wb        = 3'd4;

  // Fill channel.
  localparam msg_type_t fill_data    = 3'd0;
  localparam msg_type_t fill_uc_data = 3'd1;

  // Response channel.
  localparam msg_type_t resp_inv_ack = 3'd0;
  localparam msg_type_t resp_coh_ack = 3'd1;
  localparam msg_type_t resp_wb      = 3'd2;
  localparam msg_type_t resp_null_wb = 3'd3;

  typedef struct packed {
    msg_type_t msg_type;
    paddr_t    addr;
    msg_size_t size;
    lce_id_t   src_id;
    lce_id_t   dst_id;
    way_t      way_id;
  } msg_header_s;

  // One bit per message type, set where the type carries data beats.
  localparam logic [7:0] req_data_mask  = 8'd1 << req_uc_wr;
  localparam logic [7:0] cmd_data_mask  = (8'd1 << cmd_data) | (8'd1 << cmd_uc_data);
  localparam logic [7:0] fill_data_mask = (8'd1 << fill_data) | (8'd1 << fill_uc_data);
  localparam logic [7:0] resp_data_mask = 8'd1 << resp_wb;

endpackage

`default_nettype wire

// File: logic/lce_trace_pkg.sv
/* Trace record formats. Record fields are only meaningful while their
   valid bit is set. Depends on lce_msg_pkg. */
`default_nettype none

package lce_trace_pkg;

  typedef enum logic [1:0] {
    lce_chan_req  = 2'd0,
    lce_chan_cmd  = 2'd1,
    lce_chan_fill = 2'd2,
    lce_chan_resp = 2'd3
  } lce_chan_e;

  typedef logic [31:0] stamp_t;
  typedef logic [15:0] lat_t;

  typedef struct packed {
    logic                     hdr_v;
    logic                     data_v;
    logic                     first_beat;
    stamp_t                   stamp;
    lce_msg_pkg::msg_header_s header;
    lce_msg_pkg::fill_data_t  data;
  } chan_rec_s;

  typedef struct packed {
    logic                 v;
    stamp_t               stamp;
    lce_msg_pkg::lce_id_t src;
    lat_t                 latency;
  } lat_rec_s;

endpackage

`default_nettype wire

// File: logic/lce_beat_tracker.sv
/* Header must stay constant over all beats of a message. Message lengths
   above max_beats_p are clamped to max_beats_p beats. */
`timescale 1ns/100ps
`default_nettype none

module lce_beat_tracker #(
  parameter lce_trace_pkg::lce_chan_e chan_p      = lce_trace_pkg::lce_chan_req,
  parameter int                       max_beats_p = 8
) (
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire                      v_i,
  input  wire                      accept_i,
  input  lce_msg_pkg::msg_header_s header_i,
  output logic                     ack_o,
  output logic                     first_o,
  output logic                     has_data_o
);

  localparam int cnt_width_lp = $clog2(max_beats_p + 1);

  localparam logic [7:0] data_mask_lp =
    (chan_p == lce_trace_pkg::lce_chan_req)  ? lce_msg_pkg::req_data_mask  :
    (chan_p == lce_trace_pkg::lce_chan_cmd)  ? lce_msg_pkg::cmd_data_mask  :
    (chan_p == lce_trace_pkg::lce_chan_fill) ? lce_msg_pkg::fill_data_mask :
                                               lce_msg_pkg::resp_data_mask;

  // Beats still to come in the current message, zero between messages.
  logic [cnt_width_lp-1:0] cnt_r;
  logic [cnt_width_lp-1:0] beats_after_first;
  int                      msg_beats;

  assign ack_o      = v_i & accept_i;
  assign has_data_o = data_mask_lp[header_i.msg_type];
  assign first_o    = ack_o & (cnt_r == '0);

  always_comb
  begin
    msg_beats = 1;
    if (has_data_o && (header_i.size > lce_msg_pkg::fill_size_lg))
    begin
      msg_beats = 1 << (header_i.size - lce_msg_pkg::fill_size_lg);
    end
    if (msg_beats > max_beats_p)
    begin
      msg_beats = max_beats_p;
    end
    beats_after_first = cnt_width_lp'(msg_beats - 1);
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cnt_r <= '0;
    end
    else if (ack_o)
    begin
      if (cnt_r == '0)
      begin
        cnt_r <= beats_after_first;
      end
      else
      begin
        cnt_r <= cnt_r - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/lce_req_latency.sv
/* A fini without a preceding init reports the count since reset.
   The count saturates at the maximum of lat_t. */
`timescale 1ns/100ps
`default_nettype none

module lce_req_latency (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     en_i,
  input  wire                     init_i,
  input  wire                     fini_i,
  input  lce_trace_pkg::stamp_t   stamp_i,
  input  lce_msg_pkg::lce_id_t    lce_id_i,
  output lce_trace_pkg::lat_rec_s lat_rec_o
);

  lce_trace_pkg::lat_t     lat_r;
  lce_trace_pkg::lat_rec_s rec_r;

  // Init wins over fini, and restarts the count from zero.
  always_ff @(posedge clk_i)
  begin
    if (rst_i || init_i)
    begin
      lat_r <= '0;
    end
    else if (lat_r != '1)
    begin
      lat_r <= lat_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rec_r.v <= 1'b0;
    end
    else
    begin
      rec_r.v <= en_i & fini_i;
    end
    if (fini_i)
    begin
      rec_r.stamp   <= stamp_i;
      rec_r.src     <= lce_id_i;
      rec_r.latency <= lat_r;
    end
  end

  assign lat_rec_o = rec_r;

endmodule

`default_nettype wire

// File: logic/lce_trace_recorder.sv
/* Records appear one cycle after the accepting beat, stamped with that cycle.
   Payload fields hold the last accepted beat and are stale while not valid. */
`timescale 1ns/100ps
`default_nettype none

module lce_trace_recorder (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire                       en_i,
  input  wire                       req_ack_i,
  input  wire                       req_first_i,
  input  wire                       req_has_data_i,
  input  lce_msg_pkg::msg_header_s  req_header_i,
  input  lce_msg_pkg::fill_data_t   req_data_i,
  input  wire                       cmd_ack_i,
  input  wire                       cmd_first_i,
  input  wire                       cmd_has_data_i,
  input  lce_msg_pkg::msg_header_s  cmd_header_i,
  input  lce_msg_pkg::fill_data_t   cmd_data_i,
  input  wire                       fill_ack_i,
  input  wire                       fill_first_i,
  input  wire                       fill_has_data_i,
  input  lce_msg_pkg::msg_header_s  fill_header_i,
  input  lce_msg_pkg::fill_data_t   fill_data_i,
  input  wire                       resp_ack_i,
  input  wire                       resp_first_i,
  input  wire                       resp_has_data_i,
  input  lce_msg_pkg::msg_header_s  resp_header_i,
  input  lce_msg_pkg::fill_data_t   resp_data_i,
  output lce_trace_pkg::stamp_t     stamp_o,
  output lce_trace_pkg::chan_rec_s  req_rec_o,
  output lce_trace_pkg::chan_rec_s  cmd_rec_o,
  output lce_trace_pkg::chan_rec_s  fill_rec_o,
  output lce_trace_pkg::chan_rec_s  resp_rec_o
);

  lce_trace_pkg::stamp_t stamp_r;

  // Channel arrays are indexed by lce_chan_e.
  logic [3:0]               ack;
  logic [3:0]               first;
  logic [3:0]               has_data;
  lce_msg_pkg::msg_header_s header [4];
  lce_msg_pkg::fill_data_t  data [4];
  lce_trace_pkg::chan_rec_s rec_r [4];

  // Free running, independent of en_i.
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      stamp_r <= '0;
    end
    else
    begin
      stamp_r <= stamp_r + 1'b1;
    end
  end

  assign stamp_o = stamp_r;

  assign ack      = {resp_ack_i, fill_ack_i, cmd_ack_i, req_ack_i};
  assign first    = {resp_first_i, fill_first_i, cmd_first_i, req_first_i};
  assign has_data = {resp_has_data_i, fill_has_data_i, cmd_has_data_i, req_has_data_i};

  assign header[0] = req_header_i;
  assign header[1] = cmd_header_i;
  assign header[2] = fill_header_i;
  assign header[3] = resp_header_i;
  assign data[0]   = req_data_i;
  assign data[1]   = cmd_data_i;
  assign data[2]   = fill_data_i;
  assign data[3]   = resp_data_i;

  for (genvar i = 0; i < 4; i++)
  begin : g_chan
    always_ff @(posedge clk_i)
    begin
      if (rst_i)
      begin
        rec_r[i].hdr_v  <= 1'b0;
        rec_r[i].data_v <= 1'b0;
      end
      else
      begin
        rec_r[i].hdr_v  <= en_i & ack[i] & first[i];
        rec_r[i].data_v <= en_i & ack[i] & has_data[i];
      end
      if (ack[i])
      begin
        rec_r[i].first_beat <= first[i];
        rec_r[i].stamp      <= stamp_r;
        rec_r[i].header     <= header[i];
        rec_r[i].data       <= data[i];
      end
    end
  end

  assign req_rec_o  = rec_r[lce_trace_pkg::lce_chan_req];
  assign cmd_rec_o  = rec_r[lce_trace_pkg::lce_chan_cmd];
  assign fill_rec_o = rec_r[lce_trace_pkg::lce_chan_fill];
  assign resp_rec_o = rec_r[lce_trace_pkg::lce_chan_resp];

endmodule

`default_nettype wire

// File: logic/lce_tracer_top.sv
/* Observes the four channels without back-pressure. The command accept is the
   consumer's yumi, the other channels use ready. */
`timescale 1ns/100ps
`default_nettype none

module lce_tracer_top #(
  parameter int max_beats_p = 8
) (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire                       en_i,
  input  lce_msg_pkg::lce_id_t      lce_id_i,
  input  wire                       req_v_i,
  input  wire                       req_ready_i,
  input  lce_msg_pkg::msg_header_s  req_header_i,
  input  lce_msg_pkg::fill_data_t   req_data_i,
  input  wire                       cmd_v_i,
  input  wire                       cmd_yumi_i,
  input  lce_msg_pkg::msg_header_s  cmd_header_i,
  input  lce_msg_pkg::fill_data_t   cmd_data_i,
  input  wire                       fill_v_i,
  input  wire                       fill_ready_i,
  input  lce_msg_pkg::msg_header_s  fill_header_i,
  input  lce_msg_pkg::fill_data_t   fill_data_i,
  input  wire                       resp_v_i,
  input  wire                       resp_ready_i,
  input  lce_msg_pkg::msg_header_s  resp_header_i,
  input  lce_msg_pkg::fill_data_t   resp_data_i,
  input  wire                       cache_req_init_i,
  input  wire                       cache_req_fini_i,
  output lce_trace_pkg::chan_rec_s  req_rec_o,
  output lce_trace_pkg::chan_rec_s  cmd_rec_o,
  output lce_trace_pkg::chan_rec_s  fill_rec_o,
  output lce_trace_pkg::chan_rec_s  resp_rec_o,
  output lce_trace_pkg::lat_rec_s   lat_rec_o
);

  logic                  req_ack, req_first, req_has_data;
  logic                  cmd_ack, cmd_first, cmd_has_data;
  logic                  fill_ack, fill_first, fill_has_data;
  logic                  resp_ack, resp_first, resp_has_data;
  lce_trace_pkg::stamp_t stamp;

  lce_beat_tracker #(
    .chan_p      (lce_trace_pkg::lce_chan_req),
    .max_beats_p (max_beats_p)
  ) req_tracker_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .v_i        (req_v_i),
    .accept_i   (req_ready_i),
    .header_i   (req_header_i),
    .ack_o      (req_ack),
    .first_o    (req_first),
    .has_data_o (req_has_data)
  );

  lce_beat_tracker #(
    .chan_p      (lce_trace_pkg::lce_chan_cmd),
    .max_beats_p (max_beats_p)
  ) cmd_tracker_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .v_i        (cmd_v_i),
    .accept_i   (cmd_yumi_i),
    .header_i   (cmd_header_i),
    .ack_o      (cmd_ack),
    .first_o    (cmd_first),
    .has_data_o (cmd_has_data)
  );

  lce_beat_tracker #(
    .chan_p      (lce_trace_pkg::lce_chan_fill),
    .max_beats_p (max_beats_p)
  ) fill_tracker_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .v_i        (fill_v_i),
    .accept_i   (fill_ready_i),
    .header_i   (fill_header_i),
    .ack_o      (fill_ack),
    .first_o    (fill_first),
    .has_data_o (fill_has_data)
  );

  lce_beat_tracker #(
    .chan_p      (lce_trace_pkg::lce_chan_resp),
    .max_beats_p (max_beats_p)
  ) resp_tracker_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .v_i        (resp_v_i),
    .accept_i   (resp_ready_i),
    .header_i   (resp_header_i),
    .ack_o      (resp_ack),
    .first_o    (resp_first),
    .has_data_o (resp_has_data)
  );

  lce_req_latency lce_req_latency_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .en_i      (en_i),
    .init_i    (cache_req_init_i),
    .fini_i    (cache_req_fini_i),
    .stamp_i   (stamp),
    .lce_id_i  (lce_id_i),
    .lat_rec_o (lat_rec_o)
  );

  lce_trace_recorder lce_trace_recorder_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .en_i            (en_i),
    .req_ack_i       (req_ack),
    .req_first_i     (req_first),
    .req_has_data_i  (req_has_data),
    .req_header_i    (req_header_i),
    .req_data_i      (req_data_i),
    .cmd_ack_i       (cmd_ack),
    .cmd_first_i     (cmd_first),
    .cmd_has_data_i  (cmd_has_data),
    .cmd_header_i    (cmd_header_i),
    .cmd_data_i      (cmd_data_i),
    .fill_ack_i      (fill_ack),
    .fill_first_i    (fill_first),
    .fill_has_data_i (fill_has_data),
    .fill_header_i   (fill_header_i),
    .fill_data_i     (fill_data_i),
    .resp_ack_i      (resp_ack),
    .resp_first_i    (resp_first),
    .resp_has_data_i (resp_has_data),
    .resp_header_i   (resp_header_i),
    .resp_data_i     (resp_data_i),
    .stamp_o         (stamp),
    .req_rec_o       (req_rec_o),
    .cmd_rec_o       (cmd_rec_o),
    .fill_rec_o      (fill_rec_o),
    .resp_rec_o      (resp_rec_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
/* Free-running clock with a reset held high for the first few rising edges.
   Reset drops 1 ns after the last of those edges. */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_p       = 8,
  parameter int reset_cycles_p = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/lce_tracer_asserts.sv
/* Bound into every lce_trace_recorder. Checks only the valid bits and the
   fields that the valid bits qualify. */
`timescale 1ns/100ps
`default_nettype none

module lce_tracer_asserts (
  input wire                      clk_i,
  input wire                      rst_i,
  input lce_trace_pkg::chan_rec_s req_rec_i,
  input lce_trace_pkg::chan_rec_s cmd_rec_i,
  input lce_trace_pkg::chan_rec_s fill_rec_i,
  input lce_trace_pkg::chan_rec_s resp_rec_i
);

  logic any_v;

  assign any_v = req_rec_i.hdr_v | req_rec_i.data_v | cmd_rec_i.hdr_v | cmd_rec_i.data_v
               | fill_rec_i.hdr_v | fill_rec_i.data_v | resp_rec_i.hdr_v | resp_rec_i.data_v;

  a_reset_clears: assert property (@(posedge clk_i) rst_i |=> !any_v)
    else $error("record valid high in the cycle after reset");

  // A header record is only ever made on the first beat.
  a_hdr_first: assert property (@(posedge clk_i) disable iff (rst_i)
    (!req_rec_i.hdr_v || req_rec_i.first_beat) && (!cmd_rec_i.hdr_v || cmd_rec_i.first_beat)
    && (!fill_rec_i.hdr_v || fill_rec_i.first_beat)
    && (!resp_rec_i.hdr_v || resp_rec_i.first_beat))
    else $error("header record without first_beat");

  a_req_data: assert property (@(posedge clk_i) disable iff (rst_i)
    req_rec_i.data_v |-> lce_msg_pkg::req_data_mask[req_rec_i.header.msg_type])
    else $error("request data record for a type without data");

  a_cmd_data: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_rec_i.data_v |-> lce_msg_pkg::cmd_data_mask[cmd_rec_i.header.msg_type])
    else $error("command data record for a type without data");

  a_fill_data: assert property (@(posedge clk_i) disable iff (rst_i)
    fill_rec_i.data_v |-> lce_msg_pkg::fill_data_mask[fill_rec_i.header.msg_type])
    else $error("fill data record for a type without data");

  a_resp_data: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_rec_i.data_v |-> lce_msg_pkg::resp_data_mask[resp_rec_i.header.msg_type])
    else $error("response data record for a type without data");

endmodule

bind lce_trace_recorder lce_tracer_asserts lce_tracer_asserts_inst (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .req_rec_i  (req_rec_o),
  .cmd_rec_i  (cmd_rec_o),
  .fill_rec_i (fill_rec_o),
  .resp_rec_i (resp_rec_o)
);

`default_nettype wire

// File: tb/lce_tracer_tb.sv
/* Plays the LCE and the cache on all channels with LFSR stimulus. Inputs change
   1 ns after the rising edge, and records are checked at the falling edge. */
`timescale 1ns/100ps
`default_nettype none

module lce_tracer_tb;

  localparam int max_beats    = 8;
  localparam int beat_timeout = 64;
  localparam int req_ch       = int'(lce_trace_pkg::lce_chan_req);
  localparam int cmd_ch       = int'(lce_trace_pkg::lce_chan_cmd);
  localparam int fill_ch      = int'(lce_trace_pkg::lce_chan_fill);
  localparam int resp_ch      = int'(lce_trace_pkg::lce_chan_resp);

  logic                     clk;
  logic                     gen_rst;
  logic                     tb_rst;
  logic                     dut_rst;
  logic                     en;
  logic                     init;
  logic                     fini;
  lce_msg_pkg::lce_id_t     lce_id;
  logic                     ch_v [4];
  logic                     ch_acc [4];
  lce_msg_pkg::msg_header_s ch_hdr [4];
  lce_msg_pkg::fill_data_t  ch_data [4];
  lce_trace_pkg::chan_rec_s ch_rec [4];
  lce_trace_pkg::lat_rec_s  lat_rec;
  string                    ch_name [4];

  // Reference model state.
  logic [31:0]              lfsr;
  logic                     armed;
  int                       m_left [4];
  lce_trace_pkg::stamp_t    m_stamp;
  lce_trace_pkg::lat_t      m_lat;
  lce_trace_pkg::chan_rec_s exp_rec [4];
  lce_trace_pkg::lat_rec_s  exp_lat;
  int                       records_checked;

  tb_clock_gen clock_gen_inst (
    .clk_o (clk),
    .rst_o (gen_rst)
  );

  assign dut_rst = gen_rst | tb_rst;

  lce_tracer_top #(
    .max_beats_p (max_beats)
  ) lce_tracer_top_inst (
    .clk_i            (clk),
    .rst_i            (dut_rst),
    .en_i             (en),
    .lce_id_i         (lce_id),
    .req_v_i          (ch_v[req_ch]),
    .req_ready_i      (ch_acc[req_ch]),
    .req_header_i     (ch_hdr[req_ch]),
    .req_data_i       (ch_data[req_ch]),
    .cmd_v_i          (ch_v[cmd_ch]),
    .cmd_yumi_i       (ch_acc[cmd_ch]),
    .cmd_header_i     (ch_hdr[cmd_ch]),
    .cmd_data_i       (ch_data[cmd_ch]),
    .fill_v_i         (ch_v[fill_ch]),
    .fill_ready_i     (ch_acc[fill_ch]),
    .fill_header_i    (ch_hdr[fill_ch]),
    .fill_data_i      (ch_data[fill_ch]),
    .resp_v_i         (ch_v[resp_ch]),
    .resp_ready_i     (ch_acc[resp_ch]),
    .resp_header_i    (ch_hdr[resp_ch]),
    .resp_data_i      (ch_data[resp_ch]),
    .cache_req_init_i (init),
    .cache_req_fini_i (fini),
    .req_rec_o        (ch_rec[req_ch]),
    .cmd_rec_o        (ch_rec[cmd_ch]),
    .fill_rec_o       (ch_rec[fill_ch]),
    .resp_rec_o       (ch_rec[resp_ch]),
    .lat_rec_o        (lat_rec)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1. It steps once per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic carries_data(input int ch, input lce_msg_pkg::msg_type_t t);
    case (ch)
      req_ch:  return t == lce_msg_pkg::req_uc_wr;
      cmd_ch:  return (t == lce_msg_pkg::cmd_data) || (t == lce_msg_pkg::cmd_uc_data);
      fill_ch: return (t == lce_msg_pkg::fill_data) || (t == lce_msg_pkg::fill_uc_data);
      default: return t == lce_msg_pkg::resp_wb;
    endcase
  endfunction

  // Data messages take max(1, bytes / 8) beats.
  function automatic int msg_beats(input int ch, input lce_msg_pkg::msg_header_s h);
    int b;
    if (!carries_data(ch, h.msg_type))
    begin
      return 1;
    end
    b = (1 << h.size) / 8;
    if (b < 1)
    begin
      b = 1;
    end
    if (b > max_beats)
    begin
      b = max_beats;
    end
    return b;
  endfunction

  function automatic lce_msg_pkg::msg_header_s random_header(input int ch, input int max_size);
    lce_msg_pkg::msg_header_s h;
    logic [31:0]              n_types;
    n_types = (ch == cmd_ch) ? 32'd5 : (ch == fill_ch) ? 32'd2 : 32'd4;
    h.msg_type = lce_msg_pkg::msg_type_t'(rand_bits(3) % n_types);
    h.addr = rand_bits(32);
    h.size = lce_msg_pkg::msg_size_t'(rand_bits(3) % (max_size + 1));
    h.src_id = lce_msg_pkg::lce_id_t'(rand_bits(2));
    h.dst_id = lce_msg_pkg::lce_id_t'(rand_bits(2));
    h.way_id = lce_msg_pkg::way_t'(rand_bits(3));
    return h;
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_chan_rec(input string name, input lce_trace_pkg::chan_rec_s got,
                                input lce_trace_pkg::chan_rec_s exp);
    logic bad;
    bad = (got.hdr_v !== exp.hdr_v) || (got.data_v !== exp.data_v);
    if (exp.hdr_v || exp.data_v)
    begin
      bad = bad || (got.first_beat !== exp.first_beat) || (got.stamp !== exp.stamp)
            || (got.header !== exp.header);
      records_checked++;
    end
    if (exp.data_v && (got.data !== exp.data))
    begin
      bad = 1'b1;
    end
    if (bad)
    begin
      $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_lat_rec(input lce_trace_pkg::lat_rec_s got,
                               input lce_trace_pkg::lat_rec_s exp);
    logic bad;
    bad = got.v !== exp.v;
    if (exp.v)
    begin
      bad = bad || (got.stamp !== exp.stamp) || (got.src !== exp.src)
            || (got.latency !== exp.latency);
      records_checked++;
    end
    if (bad)
    begin
      $display("FAILED at %0d ns: lat_rec_o got %h expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  // Outputs hold the records of the previous cycle here and inputs are stable.
  always @(negedge clk)
  begin
    logic is_first;
    if (armed)
    begin
      for (int i = 0; i < 4; i++)
      begin
        check_chan_rec(ch_name[i], ch_rec[i], exp_rec[i]);
      end
      check_lat_rec(lat_rec, exp_lat);
    end
    if (dut_rst)
    begin
      armed = 1'b1;
      m_stamp = '0;
      m_lat = '0;
      exp_lat.v = 1'b0;
      for (int i = 0; i < 4; i++)
      begin
        m_left[i] = 0;
        exp_rec[i].hdr_v = 1'b0;
        exp_rec[i].data_v = 1'b0;
      end
    end
    else
    begin
      for (int i = 0; i < 4; i++)
      begin
        exp_rec[i].hdr_v = 1'b0;
        exp_rec[i].data_v = 1'b0;
        if (ch_v[i] && ch_acc[i])
        begin
          is_first = (m_left[i] == 0);
          exp_rec[i].hdr_v = en && is_first;
          exp_rec[i].data_v = en && carries_data(i, ch_hdr[i].msg_type);
          exp_rec[i].first_beat = is_first;
          exp_rec[i].stamp = m_stamp;
          exp_rec[i].header = ch_hdr[i];
          exp_rec[i].data = ch_data[i];
          m_left[i] = is_first ? msg_beats(i, ch_hdr[i]) - 1 : m_left[i] - 1;
        end
      end
      exp_lat.v = en && fini;
      if (fini)
      begin
        exp_lat.stamp = m_stamp;
        exp_lat.src = lce_id;
        exp_lat.latency = m_lat;
      end
      if (init)
      begin
        m_lat = '0;
      end
      else if (m_lat != '1)
      begin
        m_lat = m_lat + 1'b1;
      end
      m_stamp = m_stamp + 1'b1;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_beats(input int ch, input lce_msg_pkg::msg_header_s h, input int beats,
                            input logic gaps);
    int   waited;
    logic taken;
    ch_hdr[ch] = h;
    for (int b = 0; b < beats; b++)
    begin
      ch_data[ch] = {rand_bits(32), rand_bits(32)};
      taken = 1'b0;
      waited = 0;
      while (!taken)
      begin
        ch_v[ch] = gaps ? (rand_bits(2) != 0) : 1'b1;
        ch_acc[ch] = gaps ? (rand_bits(2) != 0) : 1'b1;
        taken = ch_v[ch] && ch_acc[ch];
        next_cycle();
        waited++;
        if (!taken && (waited > beat_timeout))
        begin
          $display("Timeout: beat %0d on channel %0d was never accepted", b, ch);
          stop_run();
        end
      end
    end
    ch_v[ch] = 1'b0;
    ch_acc[ch] = 1'b0;
  endtask

  task automatic send_msg(input int ch, input lce_msg_pkg::msg_header_s h, input logic gaps);
    send_beats(ch, h, msg_beats(ch, h), gaps);
  endtask

  task automatic drop_enable(input int delay, input int width);
    repeat (delay) next_cycle();
    en = 1'b0;
    repeat (width) next_cycle();
    en = 1'b1;
  endtask

  task automatic measure_latency(input int delay);
    int waited;
    lce_id = lce_msg_pkg::lce_id_t'(rand_bits(2));
    init = 1'b1;
    next_cycle();
    init = 1'b0;
    repeat (delay - 1) next_cycle();
    fini = 1'b1;
    next_cycle();
    fini = 1'b0;
    waited = 0;
    while (!lat_rec.v)
    begin
      next_cycle();
      waited++;
      if (waited > 4)
      begin
        $display("Timeout: no latency record after the request finished");
        stop_run();
      end
    end
    next_cycle();
  endtask

  initial
  begin
    lce_msg_pkg::msg_header_s h;
    int                       waited;
    lfsr = 32'h37509c8f;
    armed = 1'b0;
    records_checked = 0;
    ch_name = '{"req_rec_o", "cmd_rec_o", "fill_rec_o", "resp_rec_o"};
    tb_rst = 1'b0;
    en = 1'b1;
    init = 1'b0;
    fini = 1'b0;
    lce_id = '0;
    for (int i = 0; i < 4; i++)
    begin
      ch_v[i] = 1'b0;
      ch_acc[i] = 1'b0;
      ch_hdr[i] = '0;
      ch_data[i] = '0;
    end
    next_cycle();
    waited = 0;
    while (gen_rst)
    begin
      next_cycle();
      waited++;
      if (waited > 10)
      begin
        $display("Timeout: reset was never released");
        stop_run();
      end
    end

    // Single-beat messages on all channels at once.
    for (int r = 0; r < 4; r++)
    begin
      fork
        send_msg(req_ch, random_header(req_ch, 3), 1'b0);
        send_msg(cmd_ch, random_header(cmd_ch, 3), 1'b0);
        send_msg(fill_ch, random_header(fill_ch, 3), 1'b0);
        send_msg(resp_ch, random_header(resp_ch, 3), 1'b0);
      join
    end

    // Eight data beats with gaps and then the start of a new message.
    h = random_header(cmd_ch, 6);
    h.msg_type = lce_msg_pkg::cmd_data;
    h.size = 3'd6;
    send_msg(cmd_ch, h, 1'b1);
    send_msg(cmd_ch, random_header(cmd_ch, 6), 1'b1);

    // Back-to-back messages without data.
    for (int r = 0; r < 3; r++)
    begin
      h = random_header(resp_ch, 6);
      h.msg_type = (r == 1) ? lce_msg_pkg::resp_coh_ack : lce_msg_pkg::resp_inv_ack;
      send_msg(resp_ch, h, 1'b0);
    end
    for (int r = 0; r < 3; r++)
    begin
      h = random_header(cmd_ch, 6);
      h.msg_type = (r == 2) ? lce_msg_pkg::cmd_inv : lce_msg_pkg::cmd_set_state;
      send_msg(cmd_ch, h, 1'b0);
    end

    h = random_header(cmd_ch, 6);
    h.msg_type = lce_msg_pkg::cmd_uc_data;
    h.size = 3'd6;
    fork
      send_msg(cmd_ch, h, 1'b1);
      drop_enable(1 + rand_bits(3), 2 + rand_bits(3));
    join
    send_msg(cmd_ch, random_header(cmd_ch, 6), 1'b1);

    for (int r = 0; r < 6; r++)
    begin
      measure_latency(1 + rand_bits(5));
    end

    // Reset in the middle of a fill message.
    h = random_header(fill_ch, 6);
    h.size = 3'd6;
    send_beats(fill_ch, h, 3, 1'b1);
    tb_rst = 1'b1;
    next_cycle();
    tb_rst = 1'b0;
    send_msg(fill_ch, h, 1'b1);

    for (int r = 0; r < 20; r++)
    begin
      fork
        send_msg(req_ch, random_header(req_ch, 6), 1'b1);
        send_msg(cmd_ch, random_header(cmd_ch, 6), 1'b1);
        send_msg(fill_ch, random_header(fill_ch, 6), 1'b1);
        send_msg(resp_ch, random_header(resp_ch, 6), 1'b1);
      join
    end

    next_cycle();
    next_cycle();
    if (records_checked > 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("No record was ever checked");
      stop_run();
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
logic/lce_msg_pkg.sv
logic/lce_trace_pkg.sv
logic/lce_beat_tracker.sv
logic/lce_req_latency.sv
logic/lce_trace_recorder.sv
logic/lce_tracer_top.sv
tb/tb_clock_gen.sv
tb/lce_tracer_asserts.sv
tb/lce_tracer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the LCE tracer testbench with Verilator.
# The run fails if the log holds the fail message or lacks the pass message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module lce_tracer_tb --Mdir obj_dir -o lce_tracer_sim || exit 1
./obj_dir/lce_tracer_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
